/* source/CorePkg.sv */
// Core package: widths, opcodes, function codes, ALU operations and the instruction word.
package CorePkg;

    localparam int DataWidth    = 32;
    localparam int AddrWidth    = 16;
    localparam int RegAddrWidth = 5;

    // Primary opcodes.
    localparam logic [5:0] OpRType = 6'h00;
    localparam logic [5:0] OpJ     = 6'h02;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpBne   = 6'h05;
    localparam logic [5:0] OpAddi  = 6'h08;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpLbu   = 6'h24;
    localparam logic [5:0] OpSb    = 6'h28;
    localparam logic [5:0] OpSw    = 6'h2b;

    // Function codes of register-format instructions.
    localparam logic [5:0] FnAdd = 6'h20;
    localparam logic [5:0] FnSub = 6'h22;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr  = 6'h25;
    localparam logic [5:0] FnSlt = 6'h2a;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt
    } AluOp;

    // One word, read as register format or as immediate format.
    // J reads its index across rs, rt and imm of the immediate view.
    typedef union packed {
        struct packed {
            logic [5:0]              opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [RegAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            logic [5:0]              funct;
        } r;
        struct packed {
            logic [5:0]              opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [15:0]             imm;
        } i;
    } InstrWord;

    // Register format, add into register 0.
    localparam logic [DataWidth-1:0] NopWord = '0;

endpackage

/* source/FetchUnit.sv */
// Fetch stage: program counter with load-use hold and branch or jump redirect.
module FetchUnit (
    input  logic                          Clock,
    input  logic                          nReset,
    input  logic                          Hold,
    input  logic                          Redirect,
    input  logic [CorePkg::AddrWidth-1:0] Target,
    output logic [CorePkg::AddrWidth-1:0] Pc
);

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            Pc <= '0;
        end else if (Redirect) begin
            // A redirect wins over a hold.
            Pc <= Target;
        end else if (!Hold) begin
            Pc <= Pc + (CorePkg::AddrWidth)'(4);
        end
    end

    // Targets are built from word offsets, so the PC stays on word boundaries.
    assert property (@(posedge Clock) disable iff (!nReset) Pc[1:0] == 2'b00);

endmodule

/* source/DecodeUnit.sv */
// Decode stage: register file with debug read, field decode and control generation.
module DecodeUnit (
    input  logic                             Clock,
    input  logic                             nReset,
    input  CorePkg::InstrWord                Instr,
    input  logic                             WriteEnable,
    input  logic [CorePkg::RegAddrWidth-1:0] WriteAddr,
    input  logic [CorePkg::DataWidth-1:0]    WriteValue,
    input  logic [CorePkg::RegAddrWidth-1:0] DebugAddr,
    output logic [CorePkg::DataWidth-1:0]    DebugData,
    output logic [CorePkg::DataWidth-1:0]    RsData,
    output logic [CorePkg::DataWidth-1:0]    RtData,
    output logic [CorePkg::RegAddrWidth-1:0] RsAddr,
    output logic [CorePkg::RegAddrWidth-1:0] RtAddr,
    output logic [CorePkg::RegAddrWidth-1:0] DestAddr,
    output logic [CorePkg::DataWidth-1:0]    Imm,
    output CorePkg::AluOp                    AluSel,
    output logic                             AluSrcImm,
    output logic                             RegWrite,
    output logic                             MemRead,
    output logic                             MemWrite,
    output logic                             ByteAccess,
    output logic                             Branch,
    output logic                             BranchOnEqual,
    output logic                             Jump,
    output logic [25:0]                      JumpIndex
);

    logic [CorePkg::DataWidth-1:0] regs [1 << CorePkg::RegAddrWidth];
    logic [5:0]                    opcode;

    // Write first, read second.
    function automatic logic [CorePkg::DataWidth-1:0] readReg(
        input logic [CorePkg::RegAddrWidth-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (WriteEnable && WriteAddr == addr) begin
            return WriteValue;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            for (int n = 0; n < (1 << CorePkg::RegAddrWidth); n++) begin
                regs[n] <= '0;
            end
        end else if (WriteEnable && WriteAddr != '0) begin
            regs[WriteAddr] <= WriteValue;
        end
    end

    always_comb begin
        RsData    = readReg(RsAddr);
        RtData    = readReg(RtAddr);
        DebugData = readReg(DebugAddr);
    end

    // ************************************************************
    // Field decode and control.
    // ************************************************************

    assign opcode = Instr.r.opcode;

    // Source addresses read as zero when the field is not a source.
    always_comb begin
        RsAddr        = Instr.i.rs;
        RtAddr        = Instr.i.rt;
        DestAddr      = Instr.i.rt;
        Imm           = {{(CorePkg::DataWidth-16){Instr.i.imm[15]}}, Instr.i.imm};
        JumpIndex     = {Instr.i.rs, Instr.i.rt, Instr.i.imm};
        AluSel        = CorePkg::AluAdd;
        AluSrcImm     = 1'b1;
        RegWrite      = 1'b0;
        MemRead       = 1'b0;
        MemWrite      = 1'b0;
        ByteAccess    = 1'b0;
        Branch        = 1'b0;
        BranchOnEqual = 1'b0;
        Jump          = 1'b0;
        case (opcode)
            CorePkg::OpRType: begin
                DestAddr  = Instr.r.rd;
                AluSrcImm = 1'b0;
                RegWrite  = 1'b1;
                case (Instr.r.funct)
                    CorePkg::FnSub: AluSel = CorePkg::AluSub;
                    CorePkg::FnAnd: AluSel = CorePkg::AluAnd;
                    CorePkg::FnOr:  AluSel = CorePkg::AluOr;
                    CorePkg::FnSlt: AluSel = CorePkg::AluSlt;
                    default:        AluSel = CorePkg::AluAdd;
                endcase
            end
            CorePkg::OpAddi: begin
                RtAddr   = '0;
                RegWrite = 1'b1;
            end
            CorePkg::OpLw, CorePkg::OpLbu: begin
                RtAddr     = '0;
                RegWrite   = 1'b1;
                MemRead    = 1'b1;
                ByteAccess = (opcode == CorePkg::OpLbu);
            end
            CorePkg::OpSw, CorePkg::OpSb: begin
                MemWrite   = 1'b1;
                ByteAccess = (opcode == CorePkg::OpSb);
            end
            CorePkg::OpBeq, CorePkg::OpBne: begin
                AluSrcImm     = 1'b0;
                Branch        = 1'b1;
                BranchOnEqual = (opcode == CorePkg::OpBeq);
            end
            CorePkg::OpJ: begin
                RsAddr = '0;
                RtAddr = '0;
                Jump   = 1'b1;
            end
            default: begin
                RsAddr = '0;
                RtAddr = '0;
            end
        endcase
    end

    // Writeback into register 0 leaves it at zero.
    assert property (@(posedge Clock) disable iff (!nReset)
        (WriteEnable && WriteAddr == '0) |=> regs[0] == '0);

endmodule

/* source/ExecuteUnit.sv */
// Execute stage: ALU, branch condition, branch and jump targets, operand selection.
module ExecuteUnit (
    input  logic [CorePkg::DataWidth-1:0] A,
    input  logic [CorePkg::DataWidth-1:0] B,
    input  logic [CorePkg::DataWidth-1:0] Imm,
    input  logic                          AluSrcImm,
    input  CorePkg::AluOp                 AluSel,
    input  logic                          Branch,
    input  logic                          BranchOnEqual,
    input  logic                          Jump,
    input  logic [25:0]                   JumpIndex,
    input  logic [CorePkg::AddrWidth-1:0] Pc,
    output logic [CorePkg::DataWidth-1:0] Result,
    output logic                          Taken,
    output logic [CorePkg::AddrWidth-1:0] Target
);

    logic [CorePkg::DataWidth-1:0] operandB;
    logic                          equal;

    // B itself carries the store data on to the memory stage.
    assign operandB = AluSrcImm ? Imm : B;

    always_comb begin
        case (AluSel)
            CorePkg::AluSub: Result = A - operandB;
            CorePkg::AluAnd: Result = A & operandB;
            CorePkg::AluOr:  Result = A | operandB;
            CorePkg::AluSlt: begin
                Result = {{(CorePkg::DataWidth-1){1'b0}}, $signed(A) < $signed(operandB)};
            end
            default:         Result = A + operandB;
        endcase
    end

    // Branches compare the two registers, never the immediate.
    assign equal = (A == B);
    assign Taken = Jump || (Branch && (BranchOnEqual ? equal : !equal));

    always_comb begin
        if (Jump) begin
            Target = {JumpIndex[CorePkg::AddrWidth-3:0], 2'b00};
        end else begin
            Target = Pc + (CorePkg::AddrWidth)'(4) + {Imm[CorePkg::AddrWidth-3:0], 2'b00};
        end
    end

endmodule

/* source/HazardUnit.sv */
// Hazard control: forwarding selects and load-use stall detection.
module HazardUnit (
    input  logic [CorePkg::RegAddrWidth-1:0] RsAddrE,
    input  logic [CorePkg::RegAddrWidth-1:0] RtAddrE,
    input  logic [CorePkg::RegAddrWidth-1:0] DestM,
    input  logic                             RegWriteM,
    input  logic [CorePkg::RegAddrWidth-1:0] DestW,
    input  logic                             RegWriteW,
    input  logic [CorePkg::RegAddrWidth-1:0] RsAddrD,
    input  logic [CorePkg::RegAddrWidth-1:0] RtAddrD,
    input  logic [CorePkg::RegAddrWidth-1:0] DestE,
    input  logic                             MemReadE,
    output logic [1:0]                       ForwardA,
    output logic [1:0]                       ForwardB,
    output logic                             Stall
);

    // 2'b10 takes the memory stage, 2'b01 writeback, 2'b00 the register file.
    // The memory stage holds the newer value.
    function automatic logic [1:0] forwardFrom(
        input logic [CorePkg::RegAddrWidth-1:0] src
    );
        if (src == '0) begin
            return 2'b00;
        end
        if (RegWriteM && DestM == src) begin
            return 2'b10;
        end
        if (RegWriteW && DestW == src) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    always_comb begin
        ForwardA = forwardFrom(RsAddrE);
        ForwardB = forwardFrom(RtAddrE);
    end

    // Load in execute, reader in decode.
    assign Stall = MemReadE && DestE != '0 && (DestE == RsAddrD || DestE == RtAddrD);

endmodule

/* source/MemoryStage.sv */
// Memory stage: store byte-lane strobes and replication, load byte extraction.
module MemoryStage (
    input  logic [1:0]                    Address,
    input  logic [CorePkg::DataWidth-1:0] StoreData,
    input  logic                          ByteAccess,
    input  logic                          MemWrite,
    input  logic [CorePkg::DataWidth-1:0] LoadWord,
    output logic [3:0]                    Strobe,
    output logic [CorePkg::DataWidth-1:0] WriteData,
    output logic [CorePkg::DataWidth-1:0] LoadValue
);

    logic [7:0] loadByte;

    always_comb begin
        if (!MemWrite) begin
            Strobe = 4'b0000;
        end else if (ByteAccess) begin
            Strobe = 4'b0001 << Address;
        end else begin
            Strobe = 4'b1111;
        end
    end

    // A byte store repeats its byte on every lane and the strobe picks the lane.
    assign WriteData = ByteAccess ? {(CorePkg::DataWidth/8){StoreData[7:0]}} : StoreData;

    // Lane 0 holds the byte at the lowest address.
    assign loadByte  = LoadWord[Address*8 +: 8];
    assign LoadValue = ByteAccess ? {{(CorePkg::DataWidth-8){1'b0}}, loadByte} : LoadWord;

endmodule

/* source/Processor.sv */
// Pipeline top: stage registers, flush and stall, forwarding and writeback selection.
module Processor (
    input  logic                             Clock,
    input  logic                             nReset,
    output logic [CorePkg::AddrWidth-1:0]    InstrAddr,
    input  logic [CorePkg::DataWidth-1:0]    InstrMem,
    output logic [CorePkg::AddrWidth-1:0]    MemAddr,
    input  logic [CorePkg::DataWidth-1:0]    MemData,
    output logic [CorePkg::DataWidth-1:0]    WriteData,
    output logic                             MemWrite,
    output logic                             MemRead,
    output logic [3:0]                       WriteStrobe,
    output logic                             nStall,
    input  logic [CorePkg::RegAddrWidth-1:0] RegAddr,
    output logic [CorePkg::DataWidth-1:0]    RegData
);

    CorePkg::InstrWord                instrD;
    logic [CorePkg::AddrWidth-1:0]    pcD, pcE;
    logic [CorePkg::DataWidth-1:0]    rsDataD, rtDataD, immD;
    logic [CorePkg::DataWidth-1:0]    rsDataE, rtDataE, immE;
    logic [CorePkg::RegAddrWidth-1:0] rsAddrD, rtAddrD, destD;
    logic [CorePkg::RegAddrWidth-1:0] rsAddrE, rtAddrE, destE, destM, destW;
    CorePkg::AluOp                    aluSelD, aluSelE;
    logic                             aluSrcImmD, aluSrcImmE;
    logic                             regWriteD, regWriteE, regWriteM, regWriteW;
    logic                             memReadD, memReadE, memReadM;
    logic                             memWriteD, memWriteE, memWriteM;
    logic                             byteAccessD, byteAccessE, byteAccessM;
    logic                             branchD, branchE, branchOnEqualD, branchOnEqualE;
    logic                             jumpD, jumpE;
    logic [25:0]                      jumpIndexD, jumpIndexE;
    logic [CorePkg::DataWidth-1:0]    operandA, operandB, aluResultE;
    logic [CorePkg::DataWidth-1:0]    aluResultM, storeDataM, loadValueM, resultW;
    logic [CorePkg::AddrWidth-1:0]    targetE;
    logic [1:0]                       forwardA, forwardB;
    logic                             takenE, stall, bubbleE;

    function automatic logic [CorePkg::DataWidth-1:0] forwardMux(
        input logic [1:0]                    sel,
        input logic [CorePkg::DataWidth-1:0] regValue
    );
        case (sel)
            2'b10:   return aluResultM;
            2'b01:   return resultW;
            default: return regValue;
        endcase
    endfunction

    assign nStall  = !stall;
    assign bubbleE = stall || takenE;

    // ************************************************************
    // Fetch and fetch/decode register.
    // ************************************************************

    FetchUnit fetch (
        .Clock   (Clock),
        .nReset  (nReset),
        .Hold    (stall),
        .Redirect(takenE),
        .Target  (targetE),
        .Pc      (InstrAddr)
    );

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            instrD <= CorePkg::NopWord;
            pcD    <= '0;
        end else if (takenE) begin
            instrD <= CorePkg::NopWord;
        end else if (!stall) begin
            instrD <= InstrMem;
            pcD    <= InstrAddr;
        end
    end

    // ************************************************************
    // Decode and decode/execute register.
    // ************************************************************

    DecodeUnit decode (
        .Clock        (Clock),
        .nReset       (nReset),
        .Instr        (instrD),
        .WriteEnable  (regWriteW),
        .WriteAddr    (destW),
        .WriteValue   (resultW),
        .DebugAddr    (RegAddr),
        .DebugData    (RegData),
        .RsData       (rsDataD),
        .RtData       (rtDataD),
        .RsAddr       (rsAddrD),
        .RtAddr       (rtAddrD),
        .DestAddr     (destD),
        .Imm          (immD),
        .AluSel       (aluSelD),
        .AluSrcImm    (aluSrcImmD),
        .RegWrite     (regWriteD),
        .MemRead      (memReadD),
        .MemWrite     (memWriteD),
        .ByteAccess   (byteAccessD),
        .Branch       (branchD),
        .BranchOnEqual(branchOnEqualD),
        .Jump         (jumpD),
        .JumpIndex    (jumpIndexD)
    );

    // A stall or a taken branch sends a NOP into execute.
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            {regWriteE, memReadE, memWriteE, branchE, jumpE} <= '0;
            rsAddrE <= '0;
            rtAddrE <= '0;
            destE   <= '0;
        end else begin
            regWriteE <= regWriteD && !bubbleE;
            memReadE  <= memReadD && !bubbleE;
            memWriteE <= memWriteD && !bubbleE;
            branchE   <= branchD && !bubbleE;
            jumpE     <= jumpD && !bubbleE;
            rsAddrE   <= bubbleE ? '0 : rsAddrD;
            rtAddrE   <= bubbleE ? '0 : rtAddrD;
            destE     <= bubbleE ? '0 : destD;
        end
    end

    always_ff @(posedge Clock) begin
        rsDataE        <= rsDataD;
        rtDataE        <= rtDataD;
        immE           <= immD;
        aluSelE        <= aluSelD;
        aluSrcImmE     <= aluSrcImmD;
        byteAccessE    <= byteAccessD;
        branchOnEqualE <= branchOnEqualD;
        jumpIndexE     <= jumpIndexD;
        pcE            <= pcD;
    end

    // ************************************************************
    // Execute, hazards and execute/memory register.
    // ************************************************************

    HazardUnit hazard (
        .RsAddrE  (rsAddrE),
        .RtAddrE  (rtAddrE),
        .DestM    (destM),
        .RegWriteM(regWriteM),
        .DestW    (destW),
        .RegWriteW(regWriteW),
        .RsAddrD  (rsAddrD),
        .RtAddrD  (rtAddrD),
        .DestE    (destE),
        .MemReadE (memReadE),
        .ForwardA (forwardA),
        .ForwardB (forwardB),
        .Stall    (stall)
    );

    always_comb begin
        operandA = forwardMux(forwardA, rsDataE);
        operandB = forwardMux(forwardB, rtDataE);
    end

    ExecuteUnit execute (
        .A            (operandA),
        .B            (operandB),
        .Imm          (immE),
        .AluSrcImm    (aluSrcImmE),
        .AluSel       (aluSelE),
        .Branch       (branchE),
        .BranchOnEqual(branchOnEqualE),
        .Jump         (jumpE),
        .JumpIndex    (jumpIndexE),
        .Pc           (pcE),
        .Result       (aluResultE),
        .Taken        (takenE),
        .Target       (targetE)
    );

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            {regWriteM, memReadM, memWriteM} <= '0;
            destM <= '0;
        end else begin
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
            destM     <= destE;
        end
    end

    always_ff @(posedge Clock) begin
        aluResultM  <= aluResultE;
        storeDataM  <= operandB;
        byteAccessM <= byteAccessE;
    end

    // ************************************************************
    // Memory access and writeback.
    // ************************************************************

    assign MemAddr  = aluResultM[CorePkg::AddrWidth-1:0];
    assign MemRead  = memReadM;
    assign MemWrite = memWriteM;

    MemoryStage memory (
        .Address   (aluResultM[1:0]),
        .StoreData (storeDataM),
        .ByteAccess(byteAccessM),
        .MemWrite  (memWriteM),
        .LoadWord  (MemData),
        .Strobe    (WriteStrobe),
        .WriteData (WriteData),
        .LoadValue (loadValueM)
    );

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            regWriteW <= 1'b0;
            destW     <= '0;
        end else begin
            regWriteW <= regWriteM;
            destW     <= destM;
        end
    end

    // Writeback selection between load data and ALU result.
    always_ff @(posedge Clock) begin
        resultW <= memReadM ? loadValueM : aluResultM;
    end

    // The load-use stall keeps every reader of a load two stages behind it.
    assert property (@(posedge Clock) disable iff (!nReset)
        memReadM |-> (forwardA != 2'b10 && forwardB != 2'b10));

    // A byte store reaches memory on exactly one lane.
    assert property (@(posedge Clock) disable iff (!nReset)
        (memWriteM && byteAccessM) |-> $onehot(WriteStrobe));

endmodule

/* tb/ProgramTable.svh */
// Test programs with data words 0 to 3, run cycles, stall cycles, register pairs and store events.
// Registers are (index, value) pairs. Stores are (byte address, strobe, data) in order.
localparam int NumEntries = 5;
localparam int MaxInstr   = 12;
localparam int MaxRegs    = 8;
localparam int MaxStores  = 3;

localparam logic [31:0] Programs [NumEntries][MaxInstr] = '{
    '{immInstr(CorePkg::OpAddi, 1, 0, 7), immInstr(CorePkg::OpAddi, 2, 0, -3),
      aluInstr(CorePkg::FnAdd, 3, 1, 2), aluInstr(CorePkg::FnSub, 4, 1, 2),
      aluInstr(CorePkg::FnAnd, 5, 1, 2), aluInstr(CorePkg::FnOr, 6, 1, 2),
      aluInstr(CorePkg::FnSlt, 7, 2, 1), aluInstr(CorePkg::FnSlt, 8, 1, 2),
      immInstr(CorePkg::OpAddi, 0, 0, 5), 0, 0, 0},
    '{immInstr(CorePkg::OpAddi, 1, 0, 1), aluInstr(CorePkg::FnAdd, 2, 1, 1),
      aluInstr(CorePkg::FnAdd, 3, 2, 1), aluInstr(CorePkg::FnSub, 4, 3, 2),
      aluInstr(CorePkg::FnAdd, 5, 4, 3), aluInstr(CorePkg::FnOr, 6, 5, 4),
      aluInstr(CorePkg::FnAnd, 7, 6, 5), aluInstr(CorePkg::FnSlt, 8, 7, 6),
      0, 0, 0, 0},
    '{immInstr(CorePkg::OpLw, 1, 0, 0), aluInstr(CorePkg::FnAdd, 2, 1, 1),
      immInstr(CorePkg::OpLw, 3, 0, 4), immInstr(CorePkg::OpAddi, 4, 0, 9),
      aluInstr(CorePkg::FnSub, 5, 3, 4), immInstr(CorePkg::OpLw, 6, 0, 8),
      immInstr(CorePkg::OpLw, 7, 6, 0), aluInstr(CorePkg::FnAdd, 8, 7, 6),
      0, 0, 0, 0},
    '{immInstr(CorePkg::OpAddi, 1, 0, 5), immInstr(CorePkg::OpAddi, 2, 0, 5),
      immInstr(CorePkg::OpBeq, 2, 1, 2), immInstr(CorePkg::OpAddi, 3, 0, 1),
      immInstr(CorePkg::OpAddi, 4, 0, 1), immInstr(CorePkg::OpBne, 2, 1, 2),
      immInstr(CorePkg::OpAddi, 5, 0, 7), jumpTo(10),
      immInstr(CorePkg::OpAddi, 6, 0, 1), immInstr(CorePkg::OpAddi, 7, 0, 1),
      immInstr(CorePkg::OpAddi, 8, 0, 3), 0},
    '{immInstr(CorePkg::OpAddi, 1, 0, 'h7A5A), immInstr(CorePkg::OpSw, 1, 0, 16),
      immInstr(CorePkg::OpSb, 1, 0, 13), immInstr(CorePkg::OpLbu, 2, 0, 13),
      immInstr(CorePkg::OpLw, 3, 0, 12), immInstr(CorePkg::OpLw, 4, 0, 16),
      immInstr(CorePkg::OpLbu, 5, 0, 14), immInstr(CorePkg::OpSb, 5, 0, 19),
      immInstr(CorePkg::OpLw, 6, 0, 16), immInstr(CorePkg::OpAddi, 0, 0, 1), 0, 0}
};

localparam logic [31:0] InitData [NumEntries][4] = '{
    '{0, 0, 0, 0}, '{0, 0, 0, 0}, '{100, 5, 4, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 32'h11223344}
};

localparam int Cycles [NumEntries]      = '{20, 20, 24, 26, 24};
localparam int Stalls [NumEntries]      = '{0, 0, 3, 0, 1};
localparam int StoreCounts [NumEntries] = '{0, 0, 0, 0, 3};

localparam logic [31:0] ExpRegs [NumEntries][MaxRegs][2] = '{
    '{'{0, 0}, '{2, 32'hFFFFFFFD}, '{3, 4}, '{4, 10},
      '{5, 5}, '{6, 32'hFFFFFFFF}, '{7, 1}, '{8, 0}},
    '{'{1, 1}, '{2, 2}, '{3, 3}, '{4, 1}, '{5, 4}, '{6, 5}, '{7, 4}, '{8, 1}},
    '{'{1, 100}, '{2, 200}, '{3, 5}, '{4, 9},
      '{5, 32'hFFFFFFFC}, '{6, 4}, '{7, 5}, '{8, 9}},
    '{'{1, 5}, '{2, 5}, '{3, 0}, '{4, 0}, '{5, 7}, '{6, 0}, '{7, 0}, '{8, 3}},
    '{'{0, 0}, '{1, 32'h7A5A}, '{2, 32'h5A}, '{3, 32'h11225A44},
      '{4, 32'h7A5A}, '{5, 32'h22}, '{6, 32'h22007A5A}, '{7, 0}}
};

localparam logic [31:0] Stores [NumEntries][MaxStores][3] = '{
    '{'{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0}},
    '{'{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0}},
    '{'{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0}},
    '{'{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0}},
    '{'{16, 4'hF, 32'h00007A5A}, '{13, 4'h2, 32'h5A5A5A5A}, '{19, 4'h8, 32'h22222222}}
};

/* tb/ProcessorTb.sv */
// Testbench for the pipelined core: clock, reset, memory models, table-driven programs, checks.
module ProcessorTb;

    logic                             Clock = 1'b0;
    logic                             nReset;
    logic [CorePkg::AddrWidth-1:0]    InstrAddr;
    logic [CorePkg::DataWidth-1:0]    InstrMem;
    logic [CorePkg::AddrWidth-1:0]    MemAddr;
    logic [CorePkg::DataWidth-1:0]    MemData;
    logic [CorePkg::DataWidth-1:0]    WriteData;
    logic                             MemWrite;
    logic                             MemRead;
    logic [3:0]                       WriteStrobe;
    logic                             nStall;
    logic [CorePkg::RegAddrWidth-1:0] RegAddr;
    logic [CorePkg::DataWidth-1:0]    RegData;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] storeAddr [$];
    logic [31:0] storeStrobe [$];
    logic [31:0] storeData [$];
    int          stallCount = 0;
    int          cycleCount = 0;

    // Small assembler for the table.
    function automatic logic [31:0] aluInstr(logic [5:0] fn, int rd, int rs, int rt);
        return {CorePkg::OpRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] immInstr(logic [5:0] op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jumpTo(int index);
        return {CorePkg::OpJ, 26'(index)};
    endfunction

    `include "ProgramTable.svh"

    function automatic int cycleBudget();
        int total;
        total = 0;
        for (int e = 0; e < NumEntries; e++) begin
            total += Cycles[e] + 16;
        end
        return total;
    endfunction

    localparam int TimeoutLimit = cycleBudget();

    Processor uut (
        .Clock      (Clock),
        .nReset     (nReset),
        .InstrAddr  (InstrAddr),
        .InstrMem   (InstrMem),
        .MemAddr    (MemAddr),
        .MemData    (MemData),
        .WriteData  (WriteData),
        .MemWrite   (MemWrite),
        .MemRead    (MemRead),
        .WriteStrobe(WriteStrobe),
        .nStall     (nStall),
        .RegAddr    (RegAddr),
        .RegData    (RegData)
    );

    // Both memories answer in the same cycle.
    assign InstrMem = imem[InstrAddr[9:2]];
    assign MemData  = dmem[MemAddr[9:2]];

    always #4 Clock = ~Clock;

    // Cycles out of reset only.
    always @(posedge Clock) begin
        if (nReset) begin
            cycleCount <= cycleCount + 1;
        end
        if (cycleCount >= TimeoutLimit) begin
            $display("Timeout: the run went past %0d cycles out of reset.", TimeoutLimit);
            $display("sim failed");
            $fatal(1, "Run stopped by the cycle limit.");
        end
    end

    // ************************************************************
    // Check and cycle tasks.
    // ************************************************************

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s: got %h, expected %h",
                     $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "Stopped at the first error.");
        end
    endtask

    // Samples right after the edge, before any DUT register moves.
    task automatic advanceClock();
        @(posedge Clock);
        if (MemWrite) begin
            storeAddr.push_back(32'(MemAddr));
            storeStrobe.push_back(32'(WriteStrobe));
            storeData.push_back(WriteData);
            for (int b = 0; b < 4; b++) begin
                if (WriteStrobe[b]) begin
                    dmem[MemAddr[9:2]][b*8 +: 8] <= WriteData[b*8 +: 8];
                end
            end
        end
        if (nReset && !nStall) begin
            stallCount++;
        end
    endtask

    // Words past the program jump to themselves, so a finished program idles.
    task automatic loadMemories(input int e);
        for (int i = 0; i < 256; i++) begin
            if (i < MaxInstr) begin
                imem[i] <= Programs[e][i];
            end else begin
                imem[i] <= jumpTo(i);
            end
            if (i < 4) begin
                dmem[i] <= InitData[e][i];
            end else begin
                dmem[i] <= $urandom();
            end
        end
    endtask

    task automatic runEntry(input int e);
        logic [4:0] index;
        advanceClock();
        nReset <= 1'b0;
        advanceClock();
        loadMemories(e);
        storeAddr.delete();
        storeStrobe.delete();
        storeData.delete();
        stallCount = 0;
        repeat (14) advanceClock();
        checkValue(32'(MemWrite), 32'd0, "MemWrite low in reset");
        checkValue(32'(MemRead), 32'd0, "MemRead low in reset");
        checkValue(32'(WriteStrobe), 32'd0, "WriteStrobe clear in reset");
        checkValue(32'(nStall), 32'd1, "nStall high in reset");
        checkValue(32'(InstrAddr), 32'd0, "InstrAddr zero in reset");
        advanceClock();
        nReset <= 1'b1;
        repeat (Cycles[e]) advanceClock();
        checkValue(stallCount, Stalls[e], $sformatf("entry %0d stall cycles", e));
        checkValue(storeAddr.size(), StoreCounts[e], $sformatf("entry %0d store count", e));
        for (int n = 0; n < StoreCounts[e]; n++) begin
            checkValue(storeAddr[n], Stores[e][n][0], $sformatf("entry %0d store %0d address", e, n));
            checkValue(storeStrobe[n], Stores[e][n][1], $sformatf("entry %0d store %0d strobe", e, n));
            checkValue(storeData[n], Stores[e][n][2], $sformatf("entry %0d store %0d data", e, n));
        end
        for (int r = 0; r < MaxRegs; r++) begin
            index = ExpRegs[e][r][0][4:0];
            RegAddr <= index;
            advanceClock();
            checkValue(RegData, ExpRegs[e][r][1], $sformatf("entry %0d r%0d", e, index));
        end
    endtask

    // ************************************************************
    // Main sequence.
    // ************************************************************

    initial begin
        nReset  <= 1'b0;
        RegAddr <= '0;
        void'($urandom(2));
        for (int e = 0; e < NumEntries; e++) begin
            runEntry(e);
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* Processor.f */
+incdir+tb
source/CorePkg.sv
source/FetchUnit.sv
source/DecodeUnit.sv
source/ExecuteUnit.sv
source/HazardUnit.sv
source/MemoryStage.sv
source/Processor.sv
tb/ProcessorTb.sv

/* Bender.yml */
package:
  name: processor

sources:
  - source/CorePkg.sv
  - source/FetchUnit.sv
  - source/DecodeUnit.sv
  - source/ExecuteUnit.sv
  - source/HazardUnit.sv
  - source/MemoryStage.sv
  - source/Processor.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/ProcessorTb.sv
